// ==== design/lsu_pkg.sv ====
package lsu_pkg;

	// Byte address map of the data port
	localparam logic [31:0] IMEM_LAST   = 32'h0000_7FFF;
	localparam logic [31:0] DRAM_BASE   = 32'h0000_8000;
	localparam logic [31:0] DRAM_LAST   = 32'h0000_8FFF;
	localparam logic [31:0] ROM_BASE    = 32'h0001_0000;
	localparam logic [31:0] ROM_LAST    = 32'h0001_01FF;
	localparam logic [31:0] PERIPH_BASE = 32'h0001_0200;

	localparam int DRAM_WORDS = 1024;
	localparam int DRAM_AW    = 10;

	typedef enum logic [1:0] {
		REG_IMEM,
		REG_DRAM,
		REG_ROM,
		REG_PERIPH
	} lsu_region_e;

	typedef enum logic [1:0] {
		RESP_OKAY,
		RESP_EXOKAY,
		RESP_SLVERR,
		RESP_DECERR
	} axi_resp_e;

	typedef logic [1:0] lsu_size_t; // 01 byte, 10 half, 11 word

	typedef union packed {
		logic [31:0]      word;
		logic [3:0][7:0]  bytes;
	} lsu_word_u;

	typedef struct packed {
		logic        we;
		lsu_region_e region;
		logic [31:0] addr;
		lsu_word_u   wdata; // Already in its byte lane
		logic [3:0]  wstrb;
		lsu_size_t   size;
	} lsu_req_t;

	// Single-beat AXI4 channels
	typedef struct packed {
		logic        valid;
		logic [31:0] addr;
		logic [2:0]  size;
	} axi_aw_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] data;
		logic [3:0]  strb;
		logic        last;
	} axi_w_t;

	typedef struct packed {
		logic      valid;
		axi_resp_e resp;
	} axi_b_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] addr;
		logic [2:0]  size;
	} axi_ar_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] data;
		axi_resp_e   resp;
		logic        last;
	} axi_r_t;

endpackage

// ==== design/lsu_req_decode.sv ====
`timescale 1ns/1ps

module lsu_req_decode import lsu_pkg::*; (
	input  logic        Axi_full,
	input  logic        rst_n_i,
	input  logic        wr_i,
	input  logic        rd_i,
	input  logic [31:0] addr_i,
	input  logic [31:0] wdata_i,
	input  lsu_size_t   size_i,
	input  logic        done_i,
	output logic        busy_o,
	output lsu_req_t    req_o,
	output logic        dram_go_o,
	output logic        axi_go_o,
	output logic        refuse_go_o
);

	logic        accept;
	logic [1:0]  off;
	lsu_region_e region;
	logic [3:0]  base_strb;

	assign accept = (wr_i | rd_i) & ~busy_o;
	assign off    = addr_i[1:0];

	always_comb begin
		if (addr_i <= IMEM_LAST)
			region = REG_IMEM;
		else if (addr_i >= DRAM_BASE && addr_i <= DRAM_LAST)
			region = REG_DRAM;
		else if (addr_i >= ROM_BASE && addr_i <= ROM_LAST)
			region = REG_ROM;
		else if (addr_i >= PERIPH_BASE)
			region = REG_PERIPH;
		else
			region = REG_IMEM; // Unmapped holes are refused too

		case (size_i)
			2'b01:   base_strb = 4'b0001;
			2'b10:   base_strb = 4'b0011;
			2'b11:   base_strb = 4'b1111;
			default: base_strb = 4'b0000; // Size 00 store writes nothing
		endcase
	end

	// Request payload, held until the next accepted strobe
	always_ff @(posedge Axi_full) begin
		if (accept) begin
			req_o.we         <= wr_i; // Store wins over load
			req_o.region     <= region;
			req_o.addr       <= addr_i;
			req_o.wdata.word <= wdata_i << {off, 3'b000};
			req_o.wstrb      <= wr_i ? base_strb << off : 4'b0000;
			req_o.size       <= size_i;
		end
	end

	always_ff @(posedge Axi_full) begin
		if (!rst_n_i) begin
			busy_o      <= 1'b0;
			dram_go_o   <= 1'b0;
			axi_go_o    <= 1'b0;
			refuse_go_o <= 1'b0;
		end else begin
			dram_go_o   <= accept && region == REG_DRAM;
			axi_go_o    <= accept && region == REG_PERIPH;
			refuse_go_o <= accept && (region == REG_IMEM || region == REG_ROM);
			if (accept)
				busy_o <= 1'b1;
			else if (done_i)
				busy_o <= 1'b0;
		end
	end

endmodule

// ==== design/lsu_data_ram.sv ====
`timescale 1ns/1ps

module lsu_data_ram import lsu_pkg::*; (
	input  logic      Axi_full,
	input  logic      rst_n_i,
	input  logic      go_i,
	input  lsu_req_t  req_i,
	output lsu_word_u rdata_o,
	output logic      done_o
);

	logic [31:0]        mem [DRAM_WORDS];
	logic [DRAM_AW-1:0] idx;

	assign idx = req_i.addr[DRAM_AW+1:2];

	// Byte-enabled write, registered read
	always_ff @(posedge Axi_full) begin
		if (go_i) begin
			if (req_i.we) begin
				for (int i = 0; i < 4; i++) begin
					if (req_i.wstrb[i])
						mem[idx][8*i +: 8] <= req_i.wdata.bytes[i];
				end
			end else begin
				rdata_o.word <= mem[idx];
			end
		end
	end

	always_ff @(posedge Axi_full) begin
		if (!rst_n_i)
			done_o <= 1'b0;
		else
			done_o <= go_i; // One cycle for loads and stores alike
	end

endmodule

// ==== design/lsu_axi_master.sv ====
`timescale 1ns/1ps

module lsu_axi_master import lsu_pkg::*; (
	input  logic      Axi_full,
	input  logic      rst_n_i,
	input  logic      go_i,
	input  lsu_req_t  req_i,
	output axi_aw_t   aw_o,
	input  logic      aw_ready_i,
	output axi_w_t    w_o,
	input  logic      w_ready_i,
	input  axi_b_t    b_i,
	output logic      b_ready_o,
	output axi_ar_t   ar_o,
	input  logic      ar_ready_i,
	input  axi_r_t    r_i,
	output logic      r_ready_o,
	output lsu_word_u rdata_o,
	output axi_resp_e resp_o,
	output logic      done_o
);

	typedef enum logic [1:0] {
		W_IDLE,
		W_ADDR,
		W_DATA,
		W_RESP
	} wr_state_e;

	typedef enum logic [1:0] {
		R_IDLE,
		R_ADDR,
		R_DATA
	} rd_state_e;

	wr_state_e  wr_state;
	rd_state_e  rd_state;
	logic [2:0] ax_size;

	// Size code to AxSIZE, 00 goes out as a word
	always_comb begin
		case (req_i.size)
			2'b01:   ax_size = 3'd0;
			2'b10:   ax_size = 3'd1;
			default: ax_size = 3'd2;
		endcase
	end

	always_ff @(posedge Axi_full) begin
		if (!rst_n_i) begin
			wr_state   <= W_IDLE;
			rd_state   <= R_IDLE;
			aw_o.valid <= 1'b0;
			w_o.valid  <= 1'b0;
			ar_o.valid <= 1'b0;
			b_ready_o  <= 1'b0;
			r_ready_o  <= 1'b0;
			done_o     <= 1'b0;
		end else begin
			done_o <= 1'b0;

			case (wr_state)
				W_IDLE: begin
					if (go_i && req_i.we) begin
						aw_o     <= '{valid: 1'b1, addr: req_i.addr, size: ax_size};
						wr_state <= W_ADDR;
					end
				end
				W_ADDR: begin
					if (aw_ready_i) begin
						aw_o.valid <= 1'b0;
						w_o        <= '{valid: 1'b1, data: req_i.wdata.word,
						                strb: req_i.wstrb, last: 1'b1};
						wr_state   <= W_DATA;
					end
				end
				W_DATA: begin
					if (w_ready_i) begin
						w_o.valid <= 1'b0;
						b_ready_o <= 1'b1;
						wr_state  <= W_RESP;
					end
				end
				W_RESP: begin
					if (b_i.valid) begin
						b_ready_o <= 1'b0;
						resp_o    <= b_i.resp;
						done_o    <= 1'b1;
						wr_state  <= W_IDLE;
					end
				end
				default: wr_state <= W_IDLE;
			endcase

			case (rd_state)
				R_IDLE: begin
					if (go_i && !req_i.we) begin
						ar_o     <= '{valid: 1'b1, addr: req_i.addr, size: ax_size};
						rd_state <= R_ADDR;
					end
				end
				R_ADDR: begin
					if (ar_ready_i) begin
						ar_o.valid <= 1'b0;
						r_ready_o  <= 1'b1;
						rd_state   <= R_DATA;
					end
				end
				R_DATA: begin
					if (r_i.valid && r_i.last) begin // Single beat only
						r_ready_o    <= 1'b0;
						rdata_o.word <= r_i.data;
						resp_o       <= r_i.resp;
						done_o       <= 1'b1;
						rd_state     <= R_IDLE;
					end
				end
				default: rd_state <= R_IDLE;
			endcase
		end
	end

endmodule

// ==== design/lsu_resp_format.sv ====
`timescale 1ns/1ps

module lsu_resp_format import lsu_pkg::*; (
	input  logic        Axi_full,
	input  logic        rst_n_i,
	input  lsu_req_t    req_i,
	input  logic        ram_done_i,
	input  logic        axi_done_i,
	input  logic        refuse_i,
	input  lsu_word_u   ram_rdata_i,
	input  lsu_word_u   axi_rdata_i,
	input  axi_resp_e   axi_resp_i,
	output logic        done_o,
	output logic [31:0] rdata_o,
	output axi_resp_e   resp_o
);

	lsu_word_u   src;
	logic [1:0]  off;
	logic [1:0]  off_hi;
	logic [31:0] load_val;

	assign src    = ram_done_i ? ram_rdata_i : axi_rdata_i;
	assign off    = req_i.addr[1:0];
	assign off_hi = off + 2'd1;

	// Lane pick and zero extension
	always_comb begin
		case (req_i.size)
			2'b01:   load_val = {24'h0, src.bytes[off]};
			2'b10:   load_val = {16'h0, src.bytes[off_hi], src.bytes[off]};
			default: load_val = src.word;
		endcase
	end

	always_ff @(posedge Axi_full) begin
		if (!rst_n_i) begin
			done_o  <= 1'b0;
			rdata_o <= '0;
			resp_o  <= RESP_OKAY;
		end else begin
			done_o <= refuse_i | ram_done_i | axi_done_i;
			if (refuse_i) begin
				rdata_o <= '0;
				resp_o  <= RESP_DECERR;
			end else if (ram_done_i || axi_done_i) begin
				resp_o <= ram_done_i ? RESP_OKAY : axi_resp_i;
				if (!req_i.we)
					rdata_o <= load_val; // Stores keep the last load value
			end
		end
	end

endmodule

// ==== design/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
	input  logic        Axi_full,
	input  logic        rst_n_i,
	input  logic        wr_i,
	input  logic        rd_i,
	input  logic [31:0] addr_i,
	input  logic [31:0] wdata_i,
	input  lsu_size_t   size_i,
	output logic        busy_o,
	output logic        done_o,
	output logic [31:0] rdata_o,
	output axi_resp_e   resp_o,
	output axi_aw_t     aw_o,
	input  logic        aw_ready_i,
	output axi_w_t      w_o,
	input  logic        w_ready_i,
	input  axi_b_t      b_i,
	output logic        b_ready_o,
	output axi_ar_t     ar_o,
	input  logic        ar_ready_i,
	input  axi_r_t      r_i,
	output logic        r_ready_o
);

	lsu_req_t  req;
	logic      dram_go;
	logic      axi_go;
	logic      refuse_go;
	lsu_word_u ram_rdata;
	logic      ram_done;
	lsu_word_u axi_rdata;
	axi_resp_e axi_resp;
	logic      axi_done;

	lsu_req_decode u_decode (
		.Axi_full    (Axi_full),
		.rst_n_i     (rst_n_i),
		.wr_i        (wr_i),
		.rd_i        (rd_i),
		.addr_i      (addr_i),
		.wdata_i     (wdata_i),
		.size_i      (size_i),
		.done_i      (done_o),
		.busy_o      (busy_o),
		.req_o       (req),
		.dram_go_o   (dram_go),
		.axi_go_o    (axi_go),
		.refuse_go_o (refuse_go)
	);

	lsu_data_ram u_ram (
		.Axi_full (Axi_full),
		.rst_n_i  (rst_n_i),
		.go_i     (dram_go),
		.req_i    (req),
		.rdata_o  (ram_rdata),
		.done_o   (ram_done)
	);

	lsu_axi_master u_axi (
		.Axi_full   (Axi_full),
		.rst_n_i    (rst_n_i),
		.go_i       (axi_go),
		.req_i      (req),
		.aw_o       (aw_o),
		.aw_ready_i (aw_ready_i),
		.w_o        (w_o),
		.w_ready_i  (w_ready_i),
		.b_i        (b_i),
		.b_ready_o  (b_ready_o),
		.ar_o       (ar_o),
		.ar_ready_i (ar_ready_i),
		.r_i        (r_i),
		.r_ready_o  (r_ready_o),
		.rdata_o    (axi_rdata),
		.resp_o     (axi_resp),
		.done_o     (axi_done)
	);

	lsu_resp_format u_format (
		.Axi_full    (Axi_full),
		.rst_n_i     (rst_n_i),
		.req_i       (req),
		.ram_done_i  (ram_done),
		.axi_done_i  (axi_done),
		.refuse_i    (refuse_go),
		.ram_rdata_i (ram_rdata),
		.axi_rdata_i (axi_rdata),
		.axi_resp_i  (axi_resp),
		.done_o      (done_o),
		.rdata_o     (rdata_o),
		.resp_o      (resp_o)
	);

endmodule

// ==== verification/lsu_axi_master_sva.sv ====
`timescale 1ns/1ps

module lsu_axi_master_sva import lsu_pkg::*; (
	input logic    Axi_full,
	input logic    rst_n_i,
	input axi_aw_t aw_o,
	input logic    aw_ready_i,
	input axi_w_t  w_o,
	input logic    w_ready_i,
	input axi_ar_t ar_o,
	input logic    ar_ready_i,
	input logic    done_o
);

	int sva_failures = 0;

	aw_hold: assert property (@(posedge Axi_full) disable iff (!rst_n_i)
		aw_o.valid && !aw_ready_i |=> aw_o.valid && $stable(aw_o))
		else begin
			sva_failures++;
			$error("AW channel changed before AWREADY");
		end

	w_hold: assert property (@(posedge Axi_full) disable iff (!rst_n_i)
		w_o.valid && !w_ready_i |=> w_o.valid && $stable(w_o))
		else begin
			sva_failures++;
			$error("W channel changed before WREADY");
		end

	ar_hold: assert property (@(posedge Axi_full) disable iff (!rst_n_i)
		ar_o.valid && !ar_ready_i |=> ar_o.valid && $stable(ar_o))
		else begin
			sva_failures++;
			$error("AR channel changed before ARREADY");
		end

	done_pulse: assert property (@(posedge Axi_full) disable iff (!rst_n_i)
		done_o |=> !done_o)
		else begin
			sva_failures++;
			$error("done_o held for two cycles");
		end

	// Valids come out of reset low
	reset_idle: assert property (@(posedge Axi_full)
		!rst_n_i |=> !aw_o.valid && !w_o.valid && !ar_o.valid)
		else begin
			sva_failures++;
			$error("AXI valid high right after reset");
		end

endmodule

bind lsu_axi_master lsu_axi_master_sva u_sva (
	.Axi_full   (Axi_full),
	.rst_n_i    (rst_n_i),
	.aw_o       (aw_o),
	.aw_ready_i (aw_ready_i),
	.w_o        (w_o),
	.w_ready_i  (w_ready_i),
	.ar_o       (ar_o),
	.ar_ready_i (ar_ready_i),
	.done_o     (done_o)
);

// ==== verification/tb_lsu.sv ====
`timescale 1ns/1ps

module tb_lsu import lsu_pkg::*; ();

	localparam int          N_TESTS     = 30;
	localparam int          TIMEOUT_NS  = N_TESTS * 64 * 4;
	localparam logic [31:0] SLVERR_BASE = 32'hF000_0000;

	typedef struct {
		logic        st;       // 1 store, 0 load
		logic [31:0] addr;
		lsu_size_t   size;
		logic [31:0] wdata;    // Unshifted, as the processor drives it
		logic [31:0] exp_data;
		axi_resp_e   exp_resp;
		int          lat;      // Strobe to done_o, 0 when set by the slave
		logic        chk_data;
		logic        busy_hit; // Second strobe while busy_o is high
	} stim_t;

	// Expected values follow lane placement, strobe mask, zero extension and region decode
	stim_t stim [N_TESTS] = '{
		'{1'b1, 32'h0000_8010, 2'b11, 32'h1234_5678, 32'h0000_0000, RESP_OKAY,   3, 1'b0, 1'b0},
		'{1'b0, 32'h0000_8010, 2'b11, 32'h0000_0000, 32'h1234_5678, RESP_OKAY,   3, 1'b1, 1'b0},
		'{1'b1, 32'h0000_8020, 2'b11, 32'hA0B0_C0D0, 32'h0000_0000, RESP_OKAY,   3, 1'b0, 1'b0},
		'{1'b1, 32'h0000_8020, 2'b01, 32'hFFFF_FF11, 32'h0000_0000, RESP_OKAY,   3, 1'b0, 1'b0},
		'{1'b1, 32'h0000_8021, 2'b01, 32'hDEAD_BE22, 32'h0000_0000, RESP_OKAY,   3, 1'b0, 1'b0},
		'{1'b1, 32'h0000_8022, 2'b01, 32'h0000_0033, 32'h0000_0000, RESP_OKAY,   3, 1'b0, 1'b0},
		'{1'b1, 32'h0000_8023, 2'b01, 32'h7777_7744, 32'h0000_0000, RESP_OKAY,   3, 1'b0, 1'b0},
		'{1'b0, 32'h0000_8020, 2'b11, 32'h0000_0000, 32'h4433_2211, RESP_OKAY,   3, 1'b1, 1'b0},
		'{1'b1, 32'h0000_8022, 2'b10, 32'h1234_BEEF, 32'h0000_0000, RESP_OKAY,   3, 1'b0, 1'b0},
		'{1'b0, 32'h0000_8020, 2'b11, 32'h0000_0000, 32'hBEEF_2211, RESP_OKAY,   3, 1'b1, 1'b0},
		'{1'b0, 32'h0000_8023, 2'b01, 32'h0000_0000, 32'h0000_00BE, RESP_OKAY,   3, 1'b1, 1'b0},
		'{1'b0, 32'h0000_8021, 2'b01, 32'h0000_0000, 32'h0000_0022, RESP_OKAY,   3, 1'b1, 1'b0},
		'{1'b0, 32'h0000_8022, 2'b10, 32'h0000_0000, 32'h0000_BEEF, RESP_OKAY,   3, 1'b1, 1'b0},
		'{1'b0, 32'h0000_8020, 2'b10, 32'h0000_0000, 32'h0000_2211, RESP_OKAY,   3, 1'b1, 1'b0},
		'{1'b1, 32'h0000_8020, 2'b00, 32'hFFFF_FFFF, 32'h0000_0000, RESP_OKAY,   3, 1'b0, 1'b0},
		'{1'b0, 32'h0000_8020, 2'b00, 32'h0000_0000, 32'hBEEF_2211, RESP_OKAY,   3, 1'b1, 1'b0},
		'{1'b0, 32'h0000_8010, 2'b11, 32'h0000_0000, 32'h1234_5678, RESP_OKAY,   3, 1'b1, 1'b1},
		'{1'b1, 32'h0002_0040, 2'b11, 32'hCAFE_F00D, 32'h0000_0000, RESP_OKAY,   0, 1'b0, 1'b0},
		'{1'b0, 32'h0002_0040, 2'b11, 32'h0000_0000, 32'hCAFE_F00D, RESP_OKAY,   0, 1'b1, 1'b0},
		'{1'b0, 32'h0000_0100, 2'b11, 32'h0000_0000, 32'h0000_0000, RESP_DECERR, 2, 1'b1, 1'b0},
		'{1'b1, 32'h0002_0041, 2'b01, 32'h0000_005A, 32'h0000_0000, RESP_OKAY,   0, 1'b0, 1'b0},
		'{1'b0, 32'h0002_0040, 2'b11, 32'h0000_0000, 32'hCAFE_5A0D, RESP_OKAY,   0, 1'b1, 1'b0},
		'{1'b1, 32'h0000_0100, 2'b11, 32'hDEAD_BEEF, 32'h0000_0000, RESP_DECERR, 2, 1'b1, 1'b0},
		'{1'b0, 32'h0002_0040, 2'b10, 32'h0000_0000, 32'h0000_5A0D, RESP_OKAY,   0, 1'b1, 1'b0},
		'{1'b0, 32'h0001_0010, 2'b01, 32'h0000_0000, 32'h0000_0000, RESP_DECERR, 2, 1'b1, 1'b0},
		'{1'b0, 32'h0002_0043, 2'b01, 32'h0000_0000, 32'h0000_00CA, RESP_OKAY,   0, 1'b1, 1'b0},
		'{1'b1, 32'h0001_01FE, 2'b10, 32'h0000_ABCD, 32'h0000_0000, RESP_DECERR, 2, 1'b1, 1'b0},
		'{1'b1, 32'hF000_0000, 2'b11, 32'h1111_2222, 32'h0000_0000, RESP_SLVERR, 0, 1'b0, 1'b0},
		'{1'b0, 32'h0002_0040, 2'b11, 32'h0000_0000, 32'hCAFE_5A0D, RESP_OKAY,   0, 1'b1, 1'b0},
		'{1'b0, 32'hF000_0000, 2'b11, 32'h0000_0000, 32'h0000_0000, RESP_SLVERR, 0, 1'b1, 1'b0}
	};

	logic        Axi_full;
	logic        rst_n_i;
	logic        wr_i;
	logic        rd_i;
	logic [31:0] addr_i;
	logic [31:0] wdata_i;
	lsu_size_t   size_i;
	logic        busy_o;
	logic        done_o;
	logic [31:0] rdata_o;
	axi_resp_e   resp_o;
	axi_aw_t     aw_o;
	logic        aw_ready_i;
	axi_w_t      w_o;
	logic        w_ready_i;
	axi_b_t      b_i;
	logic        b_ready_o;
	axi_ar_t     ar_o;
	logic        ar_ready_i;
	axi_r_t      r_i;
	logic        r_ready_o;

	logic [31:0] periph_mem [256];
	logic [31:0] lcg_state = 32'h5bd2;
	logic [2:0]  exp_axsize = 3'd2;
	int          errors = 0;

	lsu_top DUT (
		.Axi_full   (Axi_full),
		.rst_n_i    (rst_n_i),
		.wr_i       (wr_i),
		.rd_i       (rd_i),
		.addr_i     (addr_i),
		.wdata_i    (wdata_i),
		.size_i     (size_i),
		.busy_o     (busy_o),
		.done_o     (done_o),
		.rdata_o    (rdata_o),
		.resp_o     (resp_o),
		.aw_o       (aw_o),
		.aw_ready_i (aw_ready_i),
		.w_o        (w_o),
		.w_ready_i  (w_ready_i),
		.b_i        (b_i),
		.b_ready_o  (b_ready_o),
		.ar_o       (ar_o),
		.ar_ready_i (ar_ready_i),
		.r_i        (r_i),
		.r_ready_o  (r_ready_o)
	);

	initial begin
		Axi_full = 1'b0;
		forever #2 Axi_full = ~Axi_full;
	end

	// Ready delay of 0 to 3 cycles
	function automatic int ready_delay();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return int'(lcg_state[17:16]);
	endfunction

	// AxSIZE is log2 of the bytes moved
	function automatic logic [2:0] axsize_of(input lsu_size_t code);
		int nbytes;
		nbytes = (code == 2'b01) ? 1 : (code == 2'b10) ? 2 : 4; // Size 00 moves a word
		return 3'($clog2(nbytes));
	endfunction

	task automatic next_cycle();
		@(posedge Axi_full);
		#1;
	endtask

	task automatic check_data(input string name, input lsu_word_u got, input lsu_word_u exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got.word, exp.word);
			errors++;
		end
	endtask

	task automatic check_resp(input string name, input axi_resp_e got, input axi_resp_e exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %s expected %s", $time, name, got.name(),
				exp.name());
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_size(input string name, input logic [2:0] got, input logic [2:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	// AXI slave, write side
	initial begin : write_slave
		logic [31:0] wa;
		axi_w_t      wbeat;
		axi_resp_e   wresp;
		aw_ready_i = 1'b0;
		w_ready_i  = 1'b0;
		b_i        = '0;
		for (int i = 0; i < 256; i++)
			periph_mem[i] = '0;
		forever begin
			next_cycle();
			if (aw_o.valid) begin
				repeat (ready_delay()) next_cycle();
				aw_ready_i = 1'b1;
				wa         = aw_o.addr;
				check_size("aw_o.size", aw_o.size, exp_axsize);
				next_cycle();
				aw_ready_i = 1'b0;
				while (!w_o.valid)
					next_cycle();
				repeat (ready_delay()) next_cycle();
				w_ready_i = 1'b1;
				wbeat     = w_o;
				check_flag("w_o.last", w_o.last, 1'b1);
				next_cycle();
				w_ready_i = 1'b0;
				if (wa >= SLVERR_BASE) begin
					wresp = RESP_SLVERR;
				end else begin
					wresp = RESP_OKAY;
					for (int i = 0; i < 4; i++) begin
						if (wbeat.strb[i])
							periph_mem[wa[9:2]][8*i +: 8] = wbeat.data[8*i +: 8];
					end
				end
				while (!b_ready_o)
					next_cycle();
				repeat (ready_delay()) next_cycle();
				b_i.resp  = wresp;
				b_i.valid = 1'b1;
				next_cycle();
				b_i.valid = 1'b0;
			end
		end
	end

	// AXI slave, read side
	initial begin : read_slave
		logic [31:0] ra;
		ar_ready_i = 1'b0;
		r_i        = '0;
		forever begin
			next_cycle();
			if (ar_o.valid) begin
				repeat (ready_delay()) next_cycle();
				ar_ready_i = 1'b1;
				ra         = ar_o.addr;
				check_size("ar_o.size", ar_o.size, exp_axsize);
				next_cycle();
				ar_ready_i = 1'b0;
				while (!r_ready_o)
					next_cycle();
				repeat (ready_delay()) next_cycle();
				if (ra >= SLVERR_BASE) begin
					r_i.data = '0; // Error reads carry no data
					r_i.resp = RESP_SLVERR;
				end else begin
					r_i.data = periph_mem[ra[9:2]];
					r_i.resp = RESP_OKAY;
				end
				r_i.last  = 1'b1;
				r_i.valid = 1'b1;
				next_cycle();
				r_i.valid = 1'b0;
			end
		end
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
		$display("Checks failed");
		$finish;
	end

	initial begin : main
		int errs_before;
		int cyc;
		int failed_tests;
		bit seen;
		rst_n_i      = 1'b0;
		wr_i         = 1'b0;
		rd_i         = 1'b0;
		addr_i       = '0;
		wdata_i      = '0;
		size_i       = '0;
		failed_tests = 0;
		repeat (8) @(posedge Axi_full);
		#1;
		rst_n_i = 1'b1;
		next_cycle();

		for (int t = 0; t < N_TESTS; t++) begin
			errs_before = errors;
			check_flag("busy_o", busy_o, 1'b0);
			exp_axsize = axsize_of(stim[t].size);
			wr_i    = stim[t].st;
			rd_i    = !stim[t].st;
			addr_i  = stim[t].addr;
			wdata_i = stim[t].wdata;
			size_i  = stim[t].size;
			cyc     = 0;
			seen    = 1'b0;
			while (!seen) begin
				next_cycle();
				cyc++;
				if (cyc == 1)
					check_flag("busy_o", busy_o, 1'b1);
				wr_i = 1'b0;
				rd_i = stim[t].busy_hit && cyc == 1; // Ignored, busy_o is high
				seen = done_o;
			end

			if (stim[t].lat != 0 && cyc != stim[t].lat) begin
				$display("Test %0d: done_o came %0d cycles after the strobe instead of %0d",
					t, cyc, stim[t].lat);
				errors++;
			end
			check_resp("resp_o", resp_o, stim[t].exp_resp);
			if (stim[t].chk_data)
				check_data("rdata_o", rdata_o, stim[t].exp_data);

			// A late completion would show up here
			repeat (3) begin
				next_cycle();
				if (done_o) begin
					$display("Test %0d: a second completion followed the first one", t);
					errors++;
				end
			end

			if (errors != errs_before)
				failed_tests++;
			$display("Test %0d %s addr %h size %b: %s", t, stim[t].st ? "store" : "load",
				stim[t].addr, stim[t].size, errors == errs_before ? "ok" : "FAILED");
		end

		if (DUT.u_axi.u_sva.sva_failures != 0) begin
			$display("The AXI master broke %0d bound assertions",
				DUT.u_axi.u_sva.sva_failures);
			errors += DUT.u_axi.u_sva.sva_failures;
		end
		$display("Tests run %0d, tests failed %0d, errors %0d", N_TESTS, failed_tests, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== vlog.f ====
design/lsu_pkg.sv
design/lsu_req_decode.sv
design/lsu_data_ram.sv
design/lsu_axi_master.sv
design/lsu_resp_format.sv
design/lsu_top.sv
verification/lsu_axi_master_sva.sv
verification/tb_lsu.sv
